//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_channel
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST PASSED
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- chan_cmd_pkg.sv
`include "chan_macros.svh"

// command side: what the master asks for and the fields it carries
package chan_cmd_pkg;

  // opcode in bits OP_MSB:OP_LSB of a command word
  typedef enum logic [`OP_MSB-`OP_LSB:0] {
    OP_NOP       = 4'd0,  // accepted, no output
    OP_SET_TAG   = 4'd1,  // tag <= arg
    OP_SET_FILL  = 4'd2,  // fill number <= data
    OP_LOAD      = 4'd3,  // buffer[arg] <= data
    OP_READ_REG  = 4'd4,  // one response word
    OP_READ_FILL = 4'd5   // header plus samples
  } cmd_opcode_e;

  // raw field slices
  typedef logic [`ARG_MSB-`ARG_LSB:0]   cmd_arg_t;
  typedef logic [`DATA_MSB-`DATA_LSB:0] cmd_data_t;

  // channel registers
  // the tag is written from the arg field and goes back out in the same slot
  typedef logic [`ARG_MSB-`ARG_LSB:0]   chan_tag_t;
  // fill number fits the data field of a response
  typedef logic [`DATA_MSB-`DATA_LSB:0] fill_num_t;

endpackage

//--- chan_link_pkg.sv
`include "chan_macros.svh"

// link side: words on the wire and the sequencing around them
package chan_link_pkg;

  typedef logic [`WORD_W-1:0] link_word_t;  // rx commands and tx words alike

  // execute unit sequencing
  typedef enum logic [1:0] {
    S_IDLE,  // waiting for a command
    S_RESP,  // one register response word
    S_HDR,   // fill header word
    S_DATA   // fill sample words
  } exec_state_e;

  // tx credits held by the channel, wide enough for TX_CREDIT_MAX
  typedef logic [$clog2(`TX_CREDIT_MAX + 1)-1:0] tx_credit_t;

endpackage

//--- chan_macros.svh
`ifndef CHAN_MACROS_SVH
`define CHAN_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// link word layout
`define WORD_W          32   // one link word, both directions
`define OP_MSB          31   // opcode field
`define OP_LSB          28
`define ARG_MSB         27   // argument field: tag, register select, address
`define ARG_LSB         16
`define DATA_MSB        15   // data field: fill number, sample, count
`define DATA_LSB        0

////////////////////////////////////////////////////////////////////////////
// sizes and limits
`define CMD_FIFO_DEPTH  4    // also the rx credits the master starts with
`define BUF_DEPTH       256  // fill buffer samples, stand-in for the DDR3
`define BUF_ADDR_W      8
`define TX_CREDIT_MAX   15   // tx credit counter saturates here

`endif

//--- channel_top.sv
`include "chan_macros.svh"

module channel_top
  import chan_cmd_pkg::*, chan_link_pkg::*;
(
  input  logic       clk125,
  input  logic       rst_n,
  input  link_word_t rx_data,       // commands from the master
  input  logic       rx_valid,
  output logic       rx_credit,
  output link_word_t tx_data,       // responses and fill data to the master
  output logic       tx_last,
  output logic       tx_valid,
  input  logic       tx_credit,
  input  logic       readout_pause
);

  // decode to execute
  logic        cmd_valid;
  cmd_opcode_e cmd_op;
  cmd_arg_t    cmd_arg;
  cmd_data_t   cmd_data;
  logic        cmd_take;

  // execute to tx
  logic        out_valid;
  link_word_t  out_word;
  logic        out_last;
  logic        out_take;

  ////////////////////////////////////////////////////////////////////////////
  // receive, execute, transmit
  cmd_decode i_cmd_decode (
    .clk125    (clk125),
    .rst_n     (rst_n),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_credit (rx_credit),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_arg   (cmd_arg),
    .cmd_data  (cmd_data),
    .cmd_take  (cmd_take)
  );

  cmd_execute i_cmd_execute (
    .clk125    (clk125),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_arg   (cmd_arg),
    .cmd_data  (cmd_data),
    .cmd_take  (cmd_take),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_last  (out_last),
    .out_take  (out_take)
  );

  link_tx i_link_tx (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .readout_pause (readout_pause),  // synchronized inside
    .tx_credit     (tx_credit),
    .out_valid     (out_valid),
    .out_word      (out_word),
    .out_last      (out_last),
    .out_take      (out_take),
    .tx_data       (tx_data),
    .tx_last       (tx_last),
    .tx_valid      (tx_valid)
  );

endmodule

//--- cmd_decode.sv
`include "chan_macros.svh"

module cmd_decode
  import chan_cmd_pkg::*, chan_link_pkg::*;
(
  input  logic        clk125,
  input  logic        rst_n,
  input  link_word_t  rx_data,    // command word from the master
  input  logic        rx_valid,
  output logic        rx_credit,  // one pulse per command popped
  output logic        cmd_valid,
  output cmd_opcode_e cmd_op,
  output cmd_arg_t    cmd_arg,
  output cmd_data_t   cmd_data,
  input  logic        cmd_take    // execute accepts the head command
);

  localparam int PTR_W = $clog2(`CMD_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`CMD_FIFO_DEPTH + 1);

  link_word_t             fifo_mem [`CMD_FIFO_DEPTH];  // raw command words
  logic       [PTR_W-1:0] wr_ptr;
  logic       [PTR_W-1:0] rd_ptr;
  logic       [CNT_W-1:0] fifo_cnt;
  logic                   push;
  logic                   pop;
  link_word_t             head;

  ////////////////////////////////////////////////////////////////////////////
  // command fifo
  assign push      = rx_valid;              // master only sends under credit
  assign pop       = cmd_take & cmd_valid;
  assign cmd_valid = (fifo_cnt != '0);      // valid the cycle after the push
  assign rx_credit = pop;                   // slot freed, credit goes back now
  assign head      = fifo_mem[rd_ptr];

  always_ff @(posedge clk125) begin
    if (push) begin
      fifo_mem[wr_ptr] <= rx_data;
    end
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;       // none, or one in one out
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // field decode of the head word
  assign cmd_arg  = head[`ARG_MSB:`ARG_LSB];
  assign cmd_data = head[`DATA_MSB:`DATA_LSB];

  always_comb begin
    case (head[`OP_MSB:`OP_LSB])
      OP_SET_TAG:   cmd_op = OP_SET_TAG;
      OP_SET_FILL:  cmd_op = OP_SET_FILL;
      OP_LOAD:      cmd_op = OP_LOAD;
      OP_READ_REG:  cmd_op = OP_READ_REG;
      OP_READ_FILL: cmd_op = OP_READ_FILL;
      default:      cmd_op = OP_NOP;         // unknown codes are swallowed
    endcase
  end

  // a word arriving on a full fifo means the master spent a credit it lacked
  a_rx_credit_respected: assert property (@(posedge clk125) disable iff (!rst_n)
    rx_valid |-> (fifo_cnt != CNT_W'(`CMD_FIFO_DEPTH)))
    else $error("command fifo overrun, rx credit violated");

endmodule

//--- cmd_execute.sv
`include "chan_macros.svh"

module cmd_execute
  import chan_cmd_pkg::*, chan_link_pkg::*;
(
  input  logic        clk125,
  input  logic        rst_n,
  input  logic        cmd_valid,
  input  cmd_opcode_e cmd_op,
  input  cmd_arg_t    cmd_arg,
  input  cmd_data_t   cmd_data,
  output logic        cmd_take,
  output logic        out_valid,
  output link_word_t  out_word,
  output logic        out_last,
  input  logic        out_take   // tx stage took out_word
);

  localparam int CNT_W = `BUF_ADDR_W + 1;  // holds 0 to BUF_DEPTH

  exec_state_e             state;
  chan_tag_t               chan_tag;
  fill_num_t               fill_num;
  cmd_data_t               fill_buf [`BUF_DEPTH];  // sample store
  logic [`BUF_ADDR_W-1:0]  rd_addr;                // next sample to send
  logic [CNT_W-1:0]        remain;                 // samples still to send
  link_word_t              resp_word;              // latched register response
  cmd_data_t               reg_value;
  cmd_data_t               sample;
  logic                    readout_done;

  // one command at a time, next one only once the last word is gone
  assign cmd_take = cmd_valid & (state == S_IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // register read mux
  always_comb begin
    case (cmd_arg)
      12'd0:   reg_value = cmd_data_t'(chan_tag);  // zero-extended
      12'd1:   reg_value = fill_num;
      default: reg_value = '0;
    endcase
  end

  // fill buffer, written by OP_LOAD, read asynchronously during readout
  always_ff @(posedge clk125) begin
    if (cmd_take && cmd_op == OP_LOAD) begin
      fill_buf[cmd_arg[`BUF_ADDR_W-1:0]] <= cmd_data;
    end
  end

  assign sample = fill_buf[rd_addr];

  // readout context, loaded on every take and stepped per data word
  always_ff @(posedge clk125) begin
    if (cmd_take) begin
      resp_word <= {OP_READ_REG, cmd_arg, reg_value};
      rd_addr   <= cmd_arg[`BUF_ADDR_W-1:0];
      // count is data[8:0], anything past BUF_DEPTH is clamped
      remain    <= cmd_data[`BUF_ADDR_W] ? CNT_W'(`BUF_DEPTH) : cmd_data[CNT_W-1:0];
    end else if (out_take && state == S_DATA) begin
      rd_addr <= rd_addr + 1'b1;  // wraps modulo BUF_DEPTH
      remain  <= remain - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequencing and channel registers
  assign readout_done = out_take & out_last & ((state == S_HDR) | (state == S_DATA));

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      chan_tag <= '0;
      fill_num <= '0;
    end else begin
      if (readout_done) fill_num <= fill_num + 1'b1;  // next fill after readout
      case (state)
        S_IDLE: begin
          if (cmd_take) begin
            case (cmd_op)
              OP_SET_TAG:   chan_tag <= cmd_arg;
              OP_SET_FILL:  fill_num <= cmd_data;
              OP_READ_REG:  state    <= S_RESP;
              OP_READ_FILL: state    <= S_HDR;
              default:      state    <= S_IDLE;  // nop, load
            endcase
          end
        end
        S_RESP:         if (out_take) state <= S_IDLE;
        S_HDR, S_DATA:  if (out_take) state <= out_last ? S_IDLE : S_DATA;
        default:        state <= S_IDLE;
      endcase
    end
  end

  // output word per state
  always_comb begin
    out_valid = 1'b1;
    out_last  = 1'b0;
    out_word  = resp_word;
    case (state)
      S_RESP: out_last = 1'b1;                          // single word
      S_HDR: begin
        out_word = {OP_READ_FILL, chan_tag, fill_num};
        out_last = (remain == '0);                      // count 0, header alone
      end
      S_DATA: begin
        out_word = {{(`OP_MSB-`OP_LSB+1){1'b0}}, cmd_arg_t'(rd_addr), sample};
        out_last = (remain == CNT_W'(1));
      end
      default: out_valid = 1'b0;
    endcase
  end

  // idle stays quiet until a read command has been taken
  a_idle_quiet: assert property (@(posedge clk125) disable iff (!rst_n)
    $rose(out_valid)
    |-> $past(cmd_take && (cmd_op == OP_READ_REG || cmd_op == OP_READ_FILL)))
    else $error("output raised without a read command");

  // a stalled word must not change under the tx stage
  a_hold_stable: assert property (@(posedge clk125) disable iff (!rst_n)
    out_valid && !out_take |=> out_valid && $stable(out_word) && $stable(out_last))
    else $error("output word changed while stalled");

endmodule

//--- link_tx.sv
`include "chan_macros.svh"

module link_tx
  import chan_link_pkg::*;
(
  input  logic       clk125,
  input  logic       rst_n,
  input  logic       readout_pause,  // async from the master
  input  logic       tx_credit,      // one pulse per free slot at the master
  input  logic       out_valid,
  input  link_word_t out_word,
  input  logic       out_last,
  output logic       out_take,
  output link_word_t tx_data,
  output logic       tx_last,
  output logic       tx_valid
);

  logic       pause_s1;
  logic       pause_s2;    // synchronized pause
  tx_credit_t credit_cnt;
  logic       word_full;   // output register holds a word
  logic       last_q;
  logic       send;

  ////////////////////////////////////////////////////////////////////////////
  // release and refill of the output register
  assign send     = word_full & (credit_cnt != '0) & ~pause_s2;
  assign out_take = out_valid & (~word_full | send);  // empty or emptying now
  assign tx_valid = send;
  assign tx_last  = send & last_q;

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      pause_s1 <= 1'b0;
      pause_s2 <= 1'b0;
    end else begin
      pause_s1 <= readout_pause;
      pause_s2 <= pause_s1;
    end
  end

  // credit counter, saturating
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else begin
      case ({tx_credit, send})
        2'b10: if (credit_cnt != tx_credit_t'(`TX_CREDIT_MAX)) credit_cnt <= credit_cnt + 1'b1;
        2'b01: credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;  // none, or one in one out
      endcase
    end
  end

  always_ff @(posedge clk125) begin
    if (!rst_n)        word_full <= 1'b0;
    else if (out_take) word_full <= 1'b1;
    else if (send)     word_full <= 1'b0;
  end

  always_ff @(posedge clk125) begin
    if (out_take) begin
      tx_data <= out_word;
      last_q  <= out_last;
    end
  end

  // after the last credit is spent nothing goes out until a new one arrives
  a_no_send_without_credit: assert property (@(posedge clk125) disable iff (!rst_n)
    tx_valid && credit_cnt == tx_credit_t'(1) && !tx_credit |=> !tx_valid)
    else $error("tx word sent without credit");

  a_credit_saturates: assert property (@(posedge clk125) disable iff (!rst_n)
    credit_cnt == tx_credit_t'(`TX_CREDIT_MAX) && tx_credit && !tx_valid
    |=> credit_cnt == tx_credit_t'(`TX_CREDIT_MAX))
    else $error("tx credit counter overflow");

endmodule

//--- src.f
+incdir+.
chan_cmd_pkg.sv
chan_link_pkg.sv
cmd_decode.sv
cmd_execute.sv
link_tx.sv
channel_top.sv
tb_channel.sv

//--- tb_channel.sv
`include "chan_macros.svh"

module tb_channel
  import chan_cmd_pkg::*, chan_link_pkg::*;
;

  localparam logic [31:0] SEED = 32'd89501;

  logic       clk125 = 1'b0;
  logic       rst_n = 1'b0;
  link_word_t rx_data = '0;
  logic       rx_valid = 1'b0;
  logic       rx_credit;
  link_word_t tx_data;
  logic       tx_last;
  logic       tx_valid;
  logic       tx_credit = 1'b0;
  logic       readout_pause = 1'b0;

  // reference model of the channel
  chan_tag_t  m_tag = '0;
  fill_num_t  m_fill = '0;
  cmd_data_t  m_buf [`BUF_DEPTH];
  link_word_t exp_words [$];            // expected tx words, in order
  logic       exp_lasts [$];

  int          rx_avail = 0;            // rx credits the master holds
  int          n_cmds = 0;
  int          n_pulses = 0;
  int          n_words = 0;
  int          n_seen = 0;
  int          cycle_cnt = 0;
  int          word_errs = 0;
  int          credit_errs = 0;
  int          other_errs = 0;
  int          credit_rate = 0;         // tx credit chance per cycle, out of 128
  logic        pause_mode = 1'b0;
  logic [31:0] stim_rng = SEED;
  logic [31:0] link_rng = ~SEED;

  channel_top i_dut (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_credit     (rx_credit),
    .tx_data       (tx_data),
    .tx_last       (tx_last),
    .tx_valid      (tx_valid),
    .tx_credit     (tx_credit),
    .readout_pause (readout_pause)
  );

  always #50 clk125 = ~clk125;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic link_word_t mk_cmd(input logic [3:0] op, input cmd_arg_t arg,
                                        input cmd_data_t data);
    return {op, arg, data};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model, one call per command in link order
  function automatic void model_cmd(input link_word_t w);
    cmd_arg_t   arg;
    cmd_data_t  data;
    cmd_data_t  val;
    int         cnt;
    logic [7:0] a;
    arg  = w[`ARG_MSB:`ARG_LSB];
    data = w[`DATA_MSB:`DATA_LSB];
    case (w[`OP_MSB:`OP_LSB])
      OP_SET_TAG:  m_tag = arg;
      OP_SET_FILL: m_fill = data;
      OP_LOAD:     m_buf[arg[7:0]] = data;
      OP_READ_REG: begin
        val = (arg == 12'd0) ? cmd_data_t'(m_tag) : (arg == 12'd1) ? m_fill : '0;
        exp_words.push_back({4'd4, arg, val});
        exp_lasts.push_back(1'b1);           // single word response
        n_words++;
      end
      OP_READ_FILL: begin
        cnt = (data[8:0] > 9'd256) ? 256 : int'(data[8:0]);
        a   = arg[7:0];
        exp_words.push_back({4'd5, m_tag, m_fill});
        exp_lasts.push_back(cnt == 0);       // header alone on count 0
        for (int i = 0; i < cnt; i++) begin
          exp_words.push_back({8'h00, a, m_buf[a]});
          exp_lasts.push_back(i == cnt - 1);
          a++;                               // wraps mod 256
        end
        n_words += cnt + 1;
        m_fill++;
      end
      default: ;                             // nop and unknown, nothing out
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and reporting
  task automatic check_word(input link_word_t got, input link_word_t exp,
                            input logic got_last, input logic exp_last);
    if (got !== exp) begin
      word_errs++;
      $display("FAILED %0t tx_data got %h expected %h", $time, got, exp);
    end
    if (got_last !== exp_last) begin
      word_errs++;
      $display("FAILED %0t tx_last got %b expected %b", $time, got_last, exp_last);
    end
  endtask

  task automatic check_credit(input tx_credit_t got, input tx_credit_t exp, input string name);
    if (got !== exp) begin
      credit_errs++;
      $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("errors: word %0d, credit %0d, other %0d", word_errs, credit_errs, other_errs);
  endtask

  // waits for a credit, then puts one command on the link
  task automatic send_cmd(input link_word_t w);
    int avail;
    forever begin
      @(posedge clk125);
      avail = rx_avail + int'(rx_credit) - int'(rx_valid);
      if (avail > 0) break;
      rx_valid <= 1'b0;
    end
    rx_valid <= 1'b1;
    rx_data  <= w;
    model_cmd(w);
    n_cmds++;
  endtask

  // every phase ends on a read, so an empty queue means all commands were taken
  task automatic wait_drain();
    @(posedge clk125);
    rx_valid <= 1'b0;
    while (exp_words.size() != 0) @(posedge clk125);
    check_credit(tx_credit_t'(n_cmds - n_pulses), '0, "rx_credit outstanding");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // master side link processes
  always @(posedge clk125) begin
    link_rng = xorshift(link_rng);
    if (!rst_n) begin
      tx_credit     <= 1'b0;
      readout_pause <= 1'b0;
    end else begin
      tx_credit <= (int'(link_rng[6:0]) < credit_rate);
      if (!pause_mode) readout_pause <= 1'b0;
      else if (link_rng[15:13] == 3'd0) readout_pause <= ~readout_pause;  // ~50% duty
    end
  end

  always @(posedge clk125) begin
    if (!rst_n) begin
      rx_avail <= `CMD_FIFO_DEPTH;
    end else begin
      if (rx_credit && rx_avail >= `CMD_FIFO_DEPTH) begin
        other_errs++;
        $display("rx credit returned with no command outstanding");
      end
      if (rx_credit) n_pulses <= n_pulses + 1;
      rx_avail <= rx_avail + int'(rx_credit) - int'(rx_valid);
    end
  end

  always @(posedge clk125) begin : compare_out
    link_word_t exp_w;
    logic       exp_l;
    if (rst_n && tx_valid) begin
      n_seen <= n_seen + 1;
      if (exp_words.size() == 0) begin
        other_errs++;
        $display("tx word %h arrived when none was expected", tx_data);
      end else begin
        exp_w = exp_words.pop_front();
        exp_l = exp_lasts.pop_front();
        check_word(tx_data, exp_w, tx_last, exp_l);
      end
    end
  end

  // limit grows with the work queued, margin covers reset and the idle wait
  always @(posedge clk125) begin
    cycle_cnt++;
    if (cycle_cnt > 40 * (n_cmds + n_words) + 200) begin
      $display("timeout after %0d cycles, %0d words still expected", cycle_cnt,
               exp_words.size());
      report_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  initial begin
    repeat (3) @(posedge clk125);
    rst_n <= 1'b1;

    // no tx credit yet, words must wait
    send_cmd(mk_cmd(OP_READ_REG, 12'd0, 16'h0));
    send_cmd(mk_cmd(OP_READ_REG, 12'd1, 16'h0));
    @(posedge clk125);
    rx_valid <= 1'b0;
    repeat (40) @(posedge clk125);
    if (n_seen != 0) begin
      other_errs++;
      $display("tx_valid raised before any tx credit was given");
    end
    credit_rate <= 128;                      // credit every cycle
    wait_drain();

    // register writes and reads, plus nop and an unknown opcode
    send_cmd(mk_cmd(OP_SET_TAG, 12'hA5C, 16'h0));
    send_cmd(mk_cmd(OP_SET_FILL, 12'h0, 16'h1234));
    send_cmd(mk_cmd(OP_NOP, 12'h3, 16'hBEEF));
    send_cmd(mk_cmd(4'hE, 12'h1, 16'h0));
    send_cmd(mk_cmd(OP_READ_REG, 12'd0, 16'h0));
    send_cmd(mk_cmd(OP_READ_REG, 12'd1, 16'h0));
    send_cmd(mk_cmd(OP_READ_REG, 12'd5, 16'h0));  // unmapped, reads 0
    wait_drain();

    // fill the whole buffer, then read it back in pieces
    for (int a = 0; a < `BUF_DEPTH; a++) begin
      stim_rng = xorshift(stim_rng);
      send_cmd(mk_cmd(OP_LOAD, cmd_arg_t'(a), stim_rng[15:0]));
    end
    send_cmd(mk_cmd(OP_READ_FILL, 12'd250, 16'd20));   // wraps past 255
    send_cmd(mk_cmd(OP_READ_FILL, 12'd17, 16'd0));     // header only
    send_cmd(mk_cmd(OP_READ_FILL, 12'd3, 16'd300));    // clamped to 256
    repeat (6) begin
      stim_rng = xorshift(stim_rng);
      send_cmd(mk_cmd(OP_READ_FILL, stim_rng[27:16],
                      {stim_rng[15:9], 3'b000, stim_rng[5:0]}));
    end
    send_cmd(mk_cmd(OP_READ_REG, 12'd1, 16'h0));
    wait_drain();

    // long readout under sparse credit and random pause
    credit_rate <= 40;
    pause_mode  <= 1'b1;
    send_cmd(mk_cmd(OP_READ_FILL, 12'd200, 16'd256));
    send_cmd(mk_cmd(OP_READ_REG, 12'd1, 16'h0));
    wait_drain();
    pause_mode <= 1'b0;

    report_counts();
    if (word_errs + credit_errs + other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
